// ==== mipsPipeline.f ====
+incdir+logic
logic/mipsPkg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsPipeline.sv
testbench/tbClock.sv
testbench/mipsPipeline_properties.sv
testbench/mipsPipelineTb.sv

// ==== testbench/mipsPipelineTb.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module mipsPipelineTb import mipsPkg::*; ();

    localparam int WAIT_LIMIT = 50;
    localparam int PROG_WORDS = 64;

    // MIPS primary opcodes and R-type function codes
    localparam logic [5:0] OPC_BEQ  = 6'h04;
    localparam logic [5:0] OPC_ADDI = 6'h08;
    localparam logic [5:0] OPC_LW   = 6'h23;
    localparam logic [5:0] OPC_SW   = 6'h2B;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2A;

    // One program word and the write-back it should retire, if any
    typedef struct {
        logic [31:0] word;
        bit          writes;
        logic [4:0]  dest;
        logic [31:0] value;
        int          test;
        string       label;
    } entryT;

    logic                   clk;
    logic                   rstN;
    logic [`DATA_WIDTH-1:0] instrAddr;
    logic [`DATA_WIDTH-1:0] instr;
    wbT                     wb;

    logic [`DATA_WIDTH-1:0] progMem [PROG_WORDS];
    entryT                  progTable [$];
    int                     expectIdx [$];
    string                  testNames [6] = '{"reset", "forwarding", "store then load",
                                              "branches", "register zero", "clean finish"};
    int                     testErrors;
    int                     testsPassed;
    int                     testsFailed;

    tbClock clockGen (.clk(clk));

    mipsPipeline DUT (
        .clk(clk),
        .rstN(rstN),
        .instrAddr(instrAddr),
        .instr(instr),
        .wb(wb)
    );

    bind mipsPipeline mipsPipeline_properties props (
        .clk(clk),
        .rstN(rstN),
        .wb(wb),
        .instrAddr(instrAddr),
        .stall(stall),
        .redirect(redirect)
    );

    // Instruction server, zero word past the end of the program
    assign instr = ($isunknown(instrAddr) || instrAddr >= PROG_WORDS * 4) ? '0
                   : progMem[instrAddr[7:2]];

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addInstr(input logic [31:0] word, input bit writes, input logic [4:0] dest,
                            input logic [31:0] value, input int test, input string label);
        progTable.push_back('{word, writes, dest, value, test, label});
    endtask

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
            testErrors++;
        end
    endtask

    // Next retirement, sampled away from the rising edge
    task automatic waitRetire(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = (wb.valid === 1'b1);
            cycles++;
        end
    endtask

    task automatic finishTest(input int test);
        if (testErrors == 0) begin
            $display("Test %0d (%s): passed", test, testNames[test]);
            testsPassed++;
        end else begin
            $display("Test %0d (%s): failed with %0d errors", test, testNames[test], testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    // Values below are worked out by hand from the instruction semantics
    task automatic buildProgram();
        addInstr(encodeI(OPC_ADDI, 0, 1, 16'd6), 1, 1, 32'd6, 1, "addi r1");
        addInstr(encodeI(OPC_ADDI, 1, 2, 16'd9), 1, 2, 32'd15, 1, "addi r2");
        addInstr(encodeR(1, 2, 3, FN_ADD), 1, 3, 32'd21, 1, "add r3");
        addInstr(encodeR(3, 1, 4, FN_SUB), 1, 4, 32'd15, 1, "sub r4");
        addInstr(encodeR(4, 3, 5, FN_AND), 1, 5, 32'd5, 1, "and r5");
        addInstr(encodeR(5, 1, 6, FN_OR), 1, 6, 32'd7, 1, "or r6");
        addInstr(encodeR(6, 4, 7, FN_SLT), 1, 7, 32'd1, 1, "slt r7");
        addInstr(encodeI(OPC_ADDI, 7, 8, 16'hFFFC), 1, 8, 32'hFFFF_FFFD, 1, "addi r8");
        addInstr(encodeR(8, 7, 9, FN_SLT), 1, 9, 32'd1, 1, "slt r9");
        addInstr(encodeR(7, 6, 10, FN_SUB), 1, 10, 32'hFFFF_FFFA, 1, "sub r10");
        // Load right after store, then a load-use pair
        addInstr(encodeI(OPC_SW, 0, 10, 16'd12), 0, 0, 0, 2, "sw r10");
        addInstr(encodeI(OPC_LW, 0, 11, 16'd12), 1, 11, 32'hFFFF_FFFA, 2, "lw r11");
        addInstr(encodeR(11, 3, 12, FN_ADD), 1, 12, 32'd15, 2, "add r12");
        // Taken beq skips two, the untaken one falls through
        addInstr(encodeI(OPC_BEQ, 7, 9, 16'd2), 0, 0, 0, 3, "beq taken");
        addInstr(encodeI(OPC_ADDI, 0, 13, 16'd99), 0, 0, 0, 3, "squashed addi r13");
        addInstr(encodeI(OPC_ADDI, 0, 14, 16'd98), 0, 0, 0, 3, "squashed addi r14");
        addInstr(encodeI(OPC_ADDI, 0, 15, 16'h55), 1, 15, 32'h55, 3, "addi r15");
        addInstr(encodeI(OPC_BEQ, 15, 0, 16'd1), 0, 0, 0, 3, "beq not taken");
        addInstr(encodeI(OPC_ADDI, 15, 16, 16'd1), 1, 16, 32'h56, 3, "addi r16");
        addInstr(encodeR(16, 15, 17, FN_ADD), 1, 17, 32'hAB, 3, "add r17");
        addInstr(encodeI(OPC_ADDI, 0, 0, 16'd77), 0, 0, 0, 4, "addi r0");
        addInstr(encodeR(0, 16, 18, FN_ADD), 1, 18, 32'h56, 4, "add r18");
        foreach (progMem[i]) progMem[i] = '0;
        foreach (progTable[i]) begin
            progMem[i] = progTable[i].word;
            if (progTable[i].writes) expectIdx.push_back(i);
        end
    endtask

    initial begin
        entryT e;
        bit    seen;
        bit    timedOut;
        rstN = 1'b0;
        testErrors = 0;
        testsPassed = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        buildProgram();

        // Reset over 16 rising edges, released on the last one
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) rstN <= 1'b1;
            @(negedge clk);
            checkValue("wb.valid during reset", {31'd0, wb.valid}, 32'd0);
        end
        checkValue("instrAddr at reset release", instrAddr, `RESET_PC);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            checkValue("wb.valid after reset", {31'd0, wb.valid}, 32'd0);
        end
        finishTest(0);

        for (int k = 0; k < expectIdx.size() && !timedOut; k++) begin
            e = progTable[expectIdx[k]];
            waitRetire(seen);
            if (!seen) begin
                $display("Timeout: %s never wrote r%0d within %0d cycles",
                         e.label, e.dest, WAIT_LIMIT);
                timedOut = 1'b1;
                testErrors++;
            end else begin
                checkValue({e.label, " dest"}, {27'd0, wb.dest}, {27'd0, e.dest});
                checkValue({e.label, " data"}, wb.data, e.value);
            end
            if (timedOut || k == expectIdx.size() - 1
                    || progTable[expectIdx[k + 1]].test != e.test) begin
                finishTest(e.test);
            end
        end

        // Only no-ops remain, so nothing else may retire
        if (!timedOut) begin
            for (int i = 0; i < 10; i++) begin
                @(negedge clk);
                if (wb.valid !== 1'b0) begin
                    $display("Unexpected write-back to r%0d at %0t ns after the program ended",
                             wb.dest, $time);
                    testErrors++;
                end
            end
            checkValue("assertion failures", DUT.props.assertFails, 32'd0);
            finishTest(5);
        end

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && !timedOut) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/mipsPipeline_properties.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module mipsPipeline_properties import mipsPkg::*; (
    input logic                   clk,
    input logic                   rstN,
    input wbT                     wb,
    input logic [`DATA_WIDTH-1:0] instrAddr,
    input logic                   stall,
    input redirectT               redirect
);

    // Failure count, read by the testbench at the end of the run
    int assertFails = 0;

    // MEM/WB comes out of reset empty
    wbClearAfterReset: assert property (@(posedge clk) !rstN |=> !wb.valid)
        else begin
            assertFails++;
            $error("wb.valid is high in the cycle after reset");
        end

    // Writes to r0 are dropped in decode
    noZeroDest: assert property (@(posedge clk) disable iff (!rstN)
        wb.valid |-> wb.dest != '0)
        else begin
            assertFails++;
            $error("write-back retired with destination r0");
        end

    // Load-use hold, unless a branch redirects fetch
    pcHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall && !redirect.taken |=> $stable(instrAddr))
        else begin
            assertFails++;
            $error("fetch address moved while the pipeline was stalled");
        end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/10ps

module tbClock #(
    parameter real PERIOD = 100.0
) (
    output logic clk
);

    // Free-running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// ==== logic/mipsPipeline.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module mipsPipeline import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [`DATA_WIDTH-1:0] instrAddr,
    input  logic [`DATA_WIDTH-1:0] instr,
    output wbT                     wb
);

    // IF/ID
    logic [`DATA_WIDTH-1:0]     ifPc4;
    logic [`DATA_WIDTH-1:0]     ifInstr;

    // Decode and register file
    logic                       stall;
    logic [`REG_ADDR_WIDTH-1:0] rfAddr1;
    logic [`REG_ADDR_WIDTH-1:0] rfAddr2;
    logic [`DATA_WIDTH-1:0]     rfData1;
    logic [`DATA_WIDTH-1:0]     rfData2;
    idExT                       idEx;

    // Execute
    redirectT                   redirect;
    exMemT                      exMem;

    fetchStage fetch (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .redirect(redirect),
        .instr(instr),
        .instrAddr(instrAddr),
        .ifPc4(ifPc4),
        .ifInstr(ifInstr)
    );

    decodeStage decode (
        .clk(clk),
        .rstN(rstN),
        .ifPc4(ifPc4),
        .ifInstr(ifInstr),
        .rfAddr1(rfAddr1),
        .rfAddr2(rfAddr2),
        .rfData1(rfData1),
        .rfData2(rfData2),
        .redirect(redirect),
        .stall(stall),
        .idEx(idEx)
    );

    regFile regs (
        .clk(clk),
        .rstN(rstN),
        .rfAddr1(rfAddr1),
        .rfAddr2(rfAddr2),
        .rfData1(rfData1),
        .rfData2(rfData2),
        .wb(wb)
    );

    executeStage execute (
        .clk(clk),
        .rstN(rstN),
        .idEx(idEx),
        .wb(wb),
        .redirect(redirect),
        .exMem(exMem)
    );

    memoryStage memory (
        .clk(clk),
        .rstN(rstN),
        .exMem(exMem),
        .wb(wb)
    );

endmodule

// ==== logic/memoryStage.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module memoryStage import mipsPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  exMemT exMem,
    output wbT    wb
);

    localparam int ADDR_BITS = $clog2(`DMEM_WORDS);

    logic [`DATA_WIDTH-1:0] dmem [`DMEM_WORDS];
    logic [ADDR_BITS-1:0]   wordIdx;
    logic [`DATA_WIDTH-1:0] loadData;

    // Byte address from the ALU, word aligned
    assign wordIdx  = exMem.aluResult[ADDR_BITS+1:2];
    assign loadData = exMem.memRead ? dmem[wordIdx] : '0;

    always_ff @(posedge clk) begin
        if (exMem.memWrite) dmem[wordIdx] <= exMem.storeData;
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        wb.dest <= exMem.dest;
        wb.data <= exMem.memToReg ? loadData : exMem.aluResult;
        if (!rstN) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= exMem.regWrite;
        end
    end

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module executeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  idExT     idEx,
    input  wbT       wb,
    output redirectT redirect,
    output exMemT    exMem
);

    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] fwdB;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluResult;

    // Youngest producer wins, r0 never forwards
    function automatic logic [`DATA_WIDTH-1:0] forward(
        input logic [`REG_ADDR_WIDTH-1:0] src,
        input logic [`DATA_WIDTH-1:0]     regVal,
        input exMemT                      exMemQ,
        input wbT                         wbQ
    );
        if (src == '0) return regVal;
        if (exMemQ.regWrite && exMemQ.dest == src) return exMemQ.aluResult;
        if (wbQ.valid && wbQ.dest == src) return wbQ.data;
        return regVal;
    endfunction

    always_comb begin
        opA  = forward(idEx.rs, idEx.readData1, exMem, wb);
        fwdB = forward(idEx.rt, idEx.readData2, exMem, wb);
        opB  = idEx.ctrl.aluSrcImm ? idEx.imm : fwdB;
    end

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD: aluResult = opA + opB;
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    // beq resolves here, target is relative to PC plus four
    assign redirect.taken  = idEx.ctrl.branch && (opA == fwdB);
    assign redirect.target = idEx.pcPlus4 + {idEx.imm[`DATA_WIDTH-3:0], 2'b00};

    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= fwdB;
        exMem.dest      <= idEx.dest;
        if (!rstN) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
        end else begin
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.memRead  <= idEx.ctrl.memRead;
            exMem.memWrite <= idEx.ctrl.memWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
        end
    end

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module decodeStage import mipsPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`DATA_WIDTH-1:0]     ifPc4,
    input  logic [`DATA_WIDTH-1:0]     ifInstr,
    output logic [`REG_ADDR_WIDTH-1:0] rfAddr1,
    output logic [`REG_ADDR_WIDTH-1:0] rfAddr2,
    input  logic [`DATA_WIDTH-1:0]     rfData1,
    input  logic [`DATA_WIDTH-1:0]     rfData2,
    input  redirectT                   redirect,
    output logic                       stall,
    output idExT                       idEx
);

    // R-type function codes
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2A;

    opcodeT                     opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] dest;
    logic [`DATA_WIDTH-1:0]     imm;
    ctrlT                       ctrl;

    assign opcode  = opcodeT'(ifInstr[31:26]);
    assign rs      = ifInstr[25:21];
    assign rt      = ifInstr[20:16];
    assign dest    = (opcode == OP_RTYPE) ? ifInstr[15:11] : rt;
    assign imm     = {{(`DATA_WIDTH-16){ifInstr[15]}}, ifInstr[15:0]};
    assign rfAddr1 = rs;
    assign rfAddr2 = rt;

    // Unknown opcodes and functions fall through as no-ops
    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (ifInstr[5:0])
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OP_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;
            end
            default: ;
        endcase
        // Writes to r0 are dropped here so they never retire
        if (dest == '0) ctrl.regWrite = 1'b0;
    end

    // Load in EX feeding the instruction in decode
    assign stall = idEx.ctrl.memRead && (idEx.rt == rs || idEx.rt == rt);

    always_ff @(posedge clk) begin
        idEx.pcPlus4   <= ifPc4;
        idEx.readData1 <= rfData1;
        idEx.readData2 <= rfData2;
        idEx.imm       <= imm;
        idEx.rs        <= rs;
        idEx.rt        <= rt;
        idEx.dest      <= dest;
        if (!rstN || stall || redirect.taken) begin
            idEx.ctrl <= '0;
        end else begin
            idEx.ctrl <= ctrl;
        end
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module regFile import mipsPkg::*; (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] rfAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] rfAddr2,
    output logic [`DATA_WIDTH-1:0]     rfData1,
    output logic [`DATA_WIDTH-1:0]     rfData2,
    input  wbT                         wb
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    // Register zero reads zero, same-cycle write passes through
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        if (addr == '0) return '0;
        if (wb.valid && wb.dest == addr) return wb.data;
        return regs[addr];
    endfunction

    always_comb begin
        rfData1 = readPort(rfAddr1);
        rfData2 = readPort(rfAddr2);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
        end else if (wb.valid && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

// ==== logic/fetchStage.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module fetchStage import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  redirectT               redirect,
    input  logic [`DATA_WIDTH-1:0] instr,
    output logic [`DATA_WIDTH-1:0] instrAddr,
    output logic [`DATA_WIDTH-1:0] ifPc4,
    output logic [`DATA_WIDTH-1:0] ifInstr
);

    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] pcPlus4;

    assign pcPlus4   = pc + `DATA_WIDTH'd4;
    assign instrAddr = pc;

    // Redirect has priority over a load-use hold
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    // IF/ID, a zero word decodes as a no-op
    always_ff @(posedge clk) begin
        if (!rstN || redirect.taken) begin
            ifInstr <= '0;
        end else if (!stall) begin
            ifInstr <= instr;
            ifPc4   <= pcPlus4;
        end
    end

endmodule

// ==== logic/mipsPkg.sv ====
`include "mips_defs.svh"

package mipsPkg;

    // Primary opcodes handled by decode
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    // Decoded control, all zero for a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT                       ctrl;
        logic [`DATA_WIDTH-1:0]     pcPlus4;
        logic [`DATA_WIDTH-1:0]     readData1;
        logic [`DATA_WIDTH-1:0]     readData2;
        logic [`DATA_WIDTH-1:0]     imm;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] dest;
    } idExT;

    typedef struct packed {
        logic                       regWrite;
        logic                       memRead;
        logic                       memWrite;
        logic                       memToReg;
        logic [`DATA_WIDTH-1:0]     aluResult;
        logic [`DATA_WIDTH-1:0]     storeData;
        logic [`REG_ADDR_WIDTH-1:0] dest;
    } exMemT;

    // One retirement per cycle at most
    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic [`DATA_WIDTH-1:0]     data;
    } wbT;

    typedef struct packed {
        logic                   taken;
        logic [`DATA_WIDTH-1:0] target;
    } redirectT;

endpackage

// ==== logic/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Datapath word width
`define DATA_WIDTH 32

// Register file geometry
`define REG_ADDR_WIDTH 5
`define NUM_REGS 32

// Data memory depth in words
`define DMEM_WORDS 64

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif
